//--- hdl/axil_mem_pkg.sv
package axil_mem_pkg;

  // Bus widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Byte offset bits inside one data word
  localparam int OFFS_W = $clog2(STRB_W);

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Request from the AXI client to the memory target
  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [STRB_W-1:0]   wmask;
  } mem_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  typedef struct packed {
    axi_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axil_r_t;

endpackage

//--- hdl/one_entry_fifo.sv
`timescale 1ns/100ps

module one_entry_fifo #(
  parameter int WIDTH_P = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic [WIDTH_P-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,

  output logic [WIDTH_P-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  logic               full_r;
  logic [WIDTH_P-1:0] data_r;

  // Only accepts while empty, so no same-cycle pass-through
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (v_i && ready_o) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_r <= data_i;
    end
  end

  a_no_yumi_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o
  );

endmodule

//--- hdl/access_timer.sv
`timescale 1ns/100ps

module access_timer #(
  parameter int WAIT_CYCLES_P = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CNT_W = (WAIT_CYCLES_P > 0) ? $clog2(WAIT_CYCLES_P + 1) : 1;

  logic [CNT_W-1:0] count_r;
  logic             running_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_r   <= '0;
      running_r <= 1'b0;
    end else if (start_i) begin
      count_r   <= CNT_W'(WAIT_CYCLES_P);
      running_r <= 1'b1;
    end else if (running_r) begin
      if (count_r == '0) begin
        running_r <= 1'b0;
      end else begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  assign done_o = running_r && (count_r == '0);

endmodule

//--- hdl/word_mem.sv
`timescale 1ns/100ps

module word_mem #(
  parameter int MEM_WORDS_P = 64
) (
  input  logic                               clk_i,
  input  logic                               we_i,
  input  logic [$clog2(MEM_WORDS_P)-1:0]     index_i,
  input  logic [axil_mem_pkg::DATA_W-1:0]    wdata_i,
  input  logic [axil_mem_pkg::STRB_W-1:0]    wmask_i,
  output logic [axil_mem_pkg::DATA_W-1:0]    rdata_o
);

  logic [axil_mem_pkg::DATA_W-1:0] mem [MEM_WORDS_P];

  // Byte lanes update independently
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < axil_mem_pkg::STRB_W; b++) begin
        if (wmask_i[b]) begin
          mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Old data on a same-cycle write
  always_ff @(posedge clk_i) begin
    rdata_o <= mem[index_i];
  end

endmodule

//--- hdl/mem_target_fsm.sv
`timescale 1ns/100ps

module mem_target_fsm #(
  parameter int MEM_WORDS_P   = 64,
  parameter int WAIT_CYCLES_P = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  axil_mem_pkg::mem_req_t          req_i,
  input  logic                            req_v_i,
  output logic                            req_ready_o,

  output logic [axil_mem_pkg::DATA_W-1:0] rsp_data_o,
  output logic                            rsp_v_o,
  input  logic                            rsp_ready_i
);

  localparam int IDX_W  = $clog2(MEM_WORDS_P);
  localparam int WORD_W = axil_mem_pkg::ADDR_W - axil_mem_pkg::OFFS_W;

  typedef enum logic [1:0] {IDLE, WAIT, RESP} state_e;

  state_e                          state_r;
  logic [IDX_W-1:0]                idx_r;
  logic [IDX_W-1:0]                req_idx;
  logic [IDX_W-1:0]                mem_idx;
  logic [WORD_W-1:0]               req_word;
  logic [axil_mem_pkg::DATA_W-1:0] mem_rdata;
  logic [axil_mem_pkg::DATA_W-1:0] rsp_data_r;
  logic                            accept;
  logic                            timer_done;

  // Word index wraps at the memory depth
  assign req_word = req_i.addr[axil_mem_pkg::ADDR_W-1:axil_mem_pkg::OFFS_W];
  assign req_idx  = IDX_W'(req_word % MEM_WORDS_P);

  assign req_ready_o = (state_r == IDLE);
  assign accept      = req_v_i & req_ready_o;
  assign mem_idx     = (state_r == IDLE) ? req_idx : idx_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
    end else begin
      case (state_r)
        IDLE: if (accept) state_r <= WAIT;
        WAIT: if (timer_done) state_r <= RESP;
        RESP: if (rsp_ready_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_r <= req_idx;
    end
    if (state_r == WAIT && timer_done) begin
      rsp_data_r <= mem_rdata;
    end
  end

  assign rsp_v_o    = (state_r == RESP);
  assign rsp_data_o = rsp_data_r;

  access_timer #(.WAIT_CYCLES_P(WAIT_CYCLES_P)) timer_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .start_i(accept), .done_o(timer_done)
  );

  // Write happens in the acceptance cycle
  word_mem #(.MEM_WORDS_P(MEM_WORDS_P)) mem_i (
    .clk_i(clk_i),
    .we_i(accept && req_i.op == axil_mem_pkg::MEM_WRITE),
    .index_i(mem_idx), .wdata_i(req_i.data), .wmask_i(req_i.wmask),
    .rdata_o(mem_rdata)
  );

  a_done_only_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) timer_done |-> state_r == WAIT
  );

endmodule

//--- hdl/axil_fifo_client.sv
`timescale 1ns/100ps

module axil_fifo_client (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  axil_mem_pkg::axil_aw_t        awpayload_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,

  input  axil_mem_pkg::axil_w_t         wpayload_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,

  output axil_mem_pkg::axil_b_t         bpayload_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,

  input  axil_mem_pkg::axil_ar_t        arpayload_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,

  output axil_mem_pkg::axil_r_t         rpayload_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,

  output axil_mem_pkg::mem_req_t        req_o,
  output logic                          req_v_o,
  input  logic                          req_ready_i,

  input  logic [axil_mem_pkg::DATA_W-1:0] rsp_data_i,
  input  logic                          rsp_v_i,
  output logic                          rsp_ready_o
);

  logic [axil_mem_pkg::ADDR_W-1:0] aw_addr;
  logic                            aw_v, aw_yumi;
  axil_mem_pkg::axil_w_t           w_head;
  logic                            w_v, w_yumi;
  logic [axil_mem_pkg::ADDR_W-1:0] ar_addr;
  logic                            ar_v, ar_yumi;
  logic                            tag_ready, tag_v, tag_yumi;
  logic                            tag_head;
  logic                            req_fire;
  logic                            tag_is_write;

  // Protection bits are not stored
  one_entry_fifo #(.WIDTH_P(axil_mem_pkg::ADDR_W)) aw_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(awpayload_i.addr), .v_i(awvalid_i), .ready_o(awready_o),
    .data_o(aw_addr), .v_o(aw_v), .yumi_i(aw_yumi)
  );

  one_entry_fifo #(.WIDTH_P($bits(axil_mem_pkg::axil_w_t))) w_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(wpayload_i), .v_i(wvalid_i), .ready_o(wready_o),
    .data_o(w_head), .v_o(w_v), .yumi_i(w_yumi)
  );

  one_entry_fifo #(.WIDTH_P(axil_mem_pkg::ADDR_W)) ar_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(arpayload_i.addr), .v_i(arvalid_i), .ready_o(arready_o),
    .data_o(ar_addr), .v_o(ar_v), .yumi_i(ar_yumi)
  );

  // Remembers which channel gets the pending response
  one_entry_fifo #(.WIDTH_P(1)) tag_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(req_o.op), .v_i(req_fire), .ready_o(tag_ready),
    .data_o(tag_head), .v_o(tag_v), .yumi_i(tag_yumi)
  );

  // Reads go first when both are pending
  always_comb begin
    req_o.op    = ar_v ? axil_mem_pkg::MEM_READ : axil_mem_pkg::MEM_WRITE;
    req_o.addr  = ar_v ? {ar_addr[axil_mem_pkg::ADDR_W-1:axil_mem_pkg::OFFS_W],
                          {axil_mem_pkg::OFFS_W{1'b0}}}
                       : aw_addr;
    req_o.data  = w_head.data;
    req_o.wmask = ar_v ? '0 : w_head.strb;
  end

  assign req_v_o  = tag_ready & (ar_v | (aw_v & w_v));
  assign req_fire = req_v_o & req_ready_i;
  assign ar_yumi  = req_fire & ar_v;
  assign aw_yumi  = req_fire & ~ar_v;
  assign w_yumi   = aw_yumi;

  // Response side
  assign tag_is_write = (tag_head == axil_mem_pkg::MEM_WRITE);
  assign rsp_ready_o  = tag_v & (tag_is_write ? bready_i : rready_i);
  assign tag_yumi     = rsp_v_i & rsp_ready_o;

  assign bvalid_o = rsp_v_i & tag_v & tag_is_write;
  assign rvalid_o = rsp_v_i & tag_v & ~tag_is_write;

  assign bpayload_o.resp = axil_mem_pkg::RESP_OKAY;
  assign rpayload_o.data = rsp_data_i;
  assign rpayload_o.resp = axil_mem_pkg::RESP_OKAY;

  // Every response from the target matches a request still waiting for it
  a_rsp_has_tag: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_v_i |-> tag_v
  );

endmodule

//--- hdl/axil_mem_top.sv
`timescale 1ns/100ps

module axil_mem_top #(
  parameter int MEM_WORDS_P   = 64,
  parameter int WAIT_CYCLES_P = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  axil_mem_pkg::axil_aw_t awpayload_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,

  input  axil_mem_pkg::axil_w_t  wpayload_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,

  output axil_mem_pkg::axil_b_t  bpayload_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,

  input  axil_mem_pkg::axil_ar_t arpayload_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,

  output axil_mem_pkg::axil_r_t  rpayload_o,
  output logic                   rvalid_o,
  input  logic                   rready_i
);

  axil_mem_pkg::mem_req_t          req;
  logic                            req_v, req_ready;
  logic [axil_mem_pkg::DATA_W-1:0] rsp_data;
  logic                            rsp_v, rsp_ready;

  axil_fifo_client client_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .awpayload_i(awpayload_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
    .wpayload_i(wpayload_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
    .bpayload_o(bpayload_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
    .arpayload_i(arpayload_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
    .rpayload_o(rpayload_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
    .req_o(req), .req_v_o(req_v), .req_ready_i(req_ready),
    .rsp_data_i(rsp_data), .rsp_v_i(rsp_v), .rsp_ready_o(rsp_ready)
  );

  mem_target_fsm #(
    .MEM_WORDS_P(MEM_WORDS_P),
    .WAIT_CYCLES_P(WAIT_CYCLES_P)
  ) target_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_i(req), .req_v_i(req_v), .req_ready_o(req_ready),
    .rsp_data_o(rsp_data), .rsp_v_o(rsp_v), .rsp_ready_i(rsp_ready)
  );

endmodule

//--- verif/tb_axil_mem.sv
`timescale 1ns/100ps

module tb_axil_mem;

  localparam int MEM_WORDS   = 64;
  localparam int TXN_TIMEOUT = 100;

  logic                   clk_i;
  logic                   rst_n_i;
  axil_mem_pkg::axil_aw_t awpayload_i;
  logic                   awvalid_i;
  logic                   awready_o;
  axil_mem_pkg::axil_w_t  wpayload_i;
  logic                   wvalid_i;
  logic                   wready_o;
  axil_mem_pkg::axil_b_t  bpayload_o;
  logic                   bvalid_o;
  logic                   bready_i;
  axil_mem_pkg::axil_ar_t arpayload_i;
  logic                   arvalid_i;
  logic                   arready_o;
  axil_mem_pkg::axil_r_t  rpayload_o;
  logic                   rvalid_o;
  logic                   rready_i;

  logic [31:0] shadow [MEM_WORDS];
  int          errors;
  int          checks;
  int          n_wr, n_rd, n_b, n_r;
  int          seed;
  bit          stop_run;

  axil_mem_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Byte lanes selected by the strobe take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic int word_index(input logic [axil_mem_pkg::ADDR_W-1:0] a);
    return int'(a[axil_mem_pkg::ADDR_W-1:2]) % MEM_WORDS;
  endfunction

  // Drives one pattern line; starts and ends on a falling edge
  task automatic run_txn(input logic [7:0] op, input logic [11:0] addr,
                         input logic [31:0] data, input logic [3:0] strb,
                         input logic [31:0] exp_rd);
    bit do_wr, do_rd;
    bit aw_done, w_done, ar_done, b_done, r_done;
    int cycles;
    int rnd;
    do_wr = (op == "W") || (op == "X");
    do_rd = (op == "R") || (op == "X");
    aw_done = !do_wr;
    w_done  = !do_wr;
    b_done  = !do_wr;
    ar_done = !do_rd;
    r_done  = !do_rd;
    if (do_rd) begin
      n_rd++;
      if (shadow[word_index(addr)] !== exp_rd) begin
        $display("Pattern read at %h expects %h but the shadow memory holds %h",
                 addr, exp_rd, shadow[word_index(addr)]);
        errors++;
      end
    end
    if (do_wr) begin
      n_wr++;
      shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
    end
    awpayload_i.addr = addr;
    awpayload_i.prot = 3'b010;
    wpayload_i.data  = data;
    wpayload_i.strb  = strb;
    arpayload_i.addr = addr;
    arpayload_i.prot = 3'b010;
    cycles = 0;
    while (!(aw_done && w_done && ar_done && b_done && r_done) && cycles < TXN_TIMEOUT) begin
      awvalid_i = !aw_done;
      wvalid_i  = !w_done;
      arvalid_i = !ar_done;
      rnd = $random(seed);
      bready_i = (rnd[1:0] != 2'b00);
      rready_i = (rnd[3:2] != 2'b00);
      // Transfers that complete on the next rising edge
      if (awvalid_i && awready_o) aw_done = 1'b1;
      if (wvalid_i && wready_o) w_done = 1'b1;
      if (arvalid_i && arready_o) ar_done = 1'b1;
      if (bvalid_o && bready_i) begin
        checks++;
        n_b++;
        b_done = 1'b1;
        if (bpayload_o.resp !== axil_mem_pkg::RESP_OKAY) begin
          $display("** Error: bpayload_o.resp = %h, expected %h", bpayload_o.resp,
                   axil_mem_pkg::RESP_OKAY);
          errors++;
        end
      end
      if (rvalid_o && rready_i) begin
        checks++;
        n_r++;
        r_done = 1'b1;
        if (rpayload_o.data !== exp_rd) begin
          $display("** Error: rpayload_o.data = %h, expected %h (address %h)",
                   rpayload_o.data, exp_rd, addr);
          errors++;
        end
        if (rpayload_o.resp !== axil_mem_pkg::RESP_OKAY) begin
          $display("** Error: rpayload_o.resp = %h, expected %h", rpayload_o.resp,
                   axil_mem_pkg::RESP_OKAY);
          errors++;
        end
      end
      @(negedge clk_i);
      cycles++;
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    arvalid_i = 1'b0;
    bready_i  = 1'b0;
    rready_i  = 1'b0;
    if (cycles >= TXN_TIMEOUT) begin
      $display("Timeout: %s transaction at address %h did not finish in %0d cycles",
               op, addr, TXN_TIMEOUT);
      errors++;
      stop_run = 1'b1;
    end
  endtask

  initial begin
    logic [7:0]  op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_rd;
    string       rest;
    int          fd;
    int          got;
    seed = 32'hc38b;
    errors = 0;
    checks = 0;
    n_wr = 0;
    n_rd = 0;
    n_b = 0;
    n_r = 0;
    stop_run = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = '0;
    rst_n_i     = 1'b0;
    awpayload_i = '0;
    awvalid_i   = 1'b0;
    wpayload_i  = '0;
    wvalid_i    = 1'b0;
    bready_i    = 1'b0;
    arpayload_i = '0;
    arvalid_i   = 1'b0;
    rready_i    = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle bus right after reset
    checks++;
    if (bvalid_o !== 1'b0 || rvalid_o !== 1'b0) begin
      $display("** Error: bvalid_o = %h, rvalid_o = %h, expected 0 after reset",
               bvalid_o, rvalid_o);
      errors++;
    end
    if (awready_o !== 1'b1 || wready_o !== 1'b1 || arready_o !== 1'b1) begin
      $display("** Error: awready_o = %h, wready_o = %h, arready_o = %h, expected 1",
               awready_o, wready_o, arready_o);
      errors++;
    end

    fd = $fopen("verif/axil_mem_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file verif/axil_mem_patterns.txt");
      errors++;
    end else begin
      while (!stop_run && $fscanf(fd, "%s", op) == 1) begin
        if (op == "#") begin
          got = $fgets(rest, fd);
        end else begin
          got = $fscanf(fd, "%h %h %h %h", addr, data, strb, exp_rd);
          if (got != 4 || (op != "W" && op != "R" && op != "X")) begin
            $display("Malformed pattern line starting with %s", op);
            errors++;
            stop_run = 1'b1;
          end else begin
            run_txn(op, addr, data, strb, exp_rd);
          end
        end
      end
      $fclose(fd);
    end

    // Nothing may still be pending once every transaction is done
    repeat (4) @(negedge clk_i);
    if (bvalid_o || rvalid_o) begin
      $display("A response is pending with no transaction outstanding");
      errors++;
    end
    if (n_wr + n_rd == 0) begin
      $display("No transactions were read from the pattern file");
      errors++;
    end
    if (n_b != n_wr || n_r != n_rd) begin
      $display("Got %0d write and %0d read responses for %0d writes and %0d reads",
               n_b, n_r, n_wr, n_rd);
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verif/axil_mem_patterns.txt
# op addr data strb expected_rdata, all hex; op W write, R read, X write and read together
# data and strb are unused on R lines, expected_rdata is unused on W lines
W 000 11223344 f 00000000
R 000 00000000 0 11223344
W 004 deadbeef f 00000000
W 004 000000aa 1 00000000
R 004 00000000 0 deadbeaa
W 004 55660000 c 00000000
R 004 00000000 0 5566beaa
W 008 cafef00d f 00000000
W 008 12345678 6 00000000
R 00b 00000000 0 ca34560d
R 006 00000000 0 5566beaa
X 000 99887766 f 11223344
R 000 00000000 0 99887766
W 104 0badf00d f 00000000
R 004 00000000 0 0badf00d
W 0fc 76543210 f 00000000
R 0fd 00000000 0 76543210
X 008 ffffffff 9 ca34560d
R 008 00000000 0 ff3456ff

//--- sim.f
hdl/axil_mem_pkg.sv
hdl/one_entry_fifo.sv
hdl/access_timer.sv
hdl/word_mem.sv
hdl/mem_target_fsm.sv
hdl/axil_fifo_client.sv
hdl/axil_mem_top.sv
verif/tb_axil_mem.sv

//--- Makefile
TOP = tb_axil_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
